//--- timer_subsys.f
design/timer_bus_pkg.sv
design/obi_slave_if.sv
design/obi_addr_decoder.sv
design/timer_unit.sv
design/obi_resp_mux.sv
design/timer_subsys_top.sv
testbench/timer_subsys_assert.sv
testbench/tb_timer_subsys.sv

//--- Makefile
TOP = tb_timer_subsys

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f timer_subsys.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_timer_subsys.sv
// timer subsystem testbench
`timescale 1ns/10ps

module tb_timer_subsys;

    typedef timer_bus_pkg::bus_word_t word_t;
    typedef timer_bus_pkg::byte_en_t  be_t;

    localparam int    NUM_TIMERS = 3;
    localparam int    TIMEOUT    = 200;  // cycles per wait
    localparam word_t EN_BIT     = word_t'(1) << timer_bus_pkg::CTRL_EN;
    localparam word_t IRQ_EN_BIT = word_t'(1) << timer_bus_pkg::CTRL_IRQ_EN;
    localparam word_t PEND_BIT   = word_t'(1) << timer_bus_pkg::CTRL_PENDING;
    localparam word_t AUTO_BIT   = word_t'(1) << timer_bus_pkg::CTRL_AUTO;

    logic                  clk_i = 1'b0;
    logic                  reset_i;
    logic                  req_i;
    logic                  we_i;
    word_t                 addr_i;
    word_t                 wdata_i;
    be_t                   be_i;
    logic                  gnt_o;
    logic                  rvalid_o;
    word_t                 rdata_o;
    logic [NUM_TIMERS-1:0] irq_o;

    // software view of each timer
    word_t model_ctrl   [NUM_TIMERS];
    word_t model_reload [NUM_TIMERS];
    word_t model_count  [NUM_TIMERS];

    word_t exp_q [$];  // expected rdata in request order
    int    error_count  = 0;
    int    check_count  = 0;
    int    test_count   = 0;
    int    failed_tests = 0;
    int    errors_at_start = 0;

    timer_subsys_top #(
        .NUM_TIMERS (NUM_TIMERS)
    ) UUT (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .we_i     (we_i),
        .addr_i   (addr_i),
        .wdata_i  (wdata_i),
        .be_i     (be_i),
        .gnt_o    (gnt_o),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o),
        .irq_o    (irq_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic word_t reg_addr(int t, logic [7:0] ofs);
        return timer_bus_pkg::TIMER_REGION_BASE
               | (word_t'(t) << timer_bus_pkg::TIMER_STRIDE_LSB) | word_t'(ofs);
    endfunction

    // outside the region or an index past the last timer
    function automatic word_t miss_addr();
        case ($urandom_range(2, 0))
            0:       return 32'h8000_0000 | word_t'($urandom);
            1:       return 32'h4000_1000 | word_t'($urandom_range(1023, 0) * 4);
            default: return reg_addr($urandom_range(15, NUM_TIMERS), 8'($urandom_range(63, 0) * 4));
        endcase
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    // expected read data for one address
    function automatic word_t ref_read(word_t addr);
        int    idx;
        word_t val;
        idx = int'(addr[timer_bus_pkg::TIMER_STRIDE_LSB +: timer_bus_pkg::TIMER_IDX_BITS]);
        val = '0;
        if ((addr & timer_bus_pkg::TIMER_REGION_MASK) == timer_bus_pkg::TIMER_REGION_BASE
            && idx < NUM_TIMERS) begin
            case (addr[7:0])
                timer_bus_pkg::REG_CTRL:   val = model_ctrl[idx];
                timer_bus_pkg::REG_RELOAD: val = model_reload[idx];
                timer_bus_pkg::REG_COUNT:  val = model_count[idx];
                default:                   val = '0;
            endcase
        end
        return val;
    endfunction

    function automatic void model_write(word_t addr, word_t wdata, be_t be);
        int idx;
        idx = int'(addr[timer_bus_pkg::TIMER_STRIDE_LSB +: timer_bus_pkg::TIMER_IDX_BITS]);
        if ((addr & timer_bus_pkg::TIMER_REGION_MASK) == timer_bus_pkg::TIMER_REGION_BASE
            && idx < NUM_TIMERS) begin
            if (addr[7:0] == timer_bus_pkg::REG_CTRL && be[0]) begin
                model_ctrl[idx] = (model_ctrl[idx] & PEND_BIT & ~(wdata & PEND_BIT))
                                  | (wdata & (EN_BIT | IRQ_EN_BIT | AUTO_BIT));
                if ((wdata & EN_BIT) != 0) begin
                    model_count[idx] = model_reload[idx];  // enable loads the counter
                end
            end else if (addr[7:0] == timer_bus_pkg::REG_RELOAD) begin
                model_reload[idx] = merge_bytes(model_reload[idx], wdata, be);
            end
        end
    endfunction

    task automatic check_value(string name, word_t expected, word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // drive one request on the falling edge and wait for its grant
    task automatic bus_issue(logic we, word_t addr, word_t wdata, be_t be, bit rvalid_due);
        int waited;
        @(negedge clk_i);
        if (rvalid_due) begin
            check_value("rvalid_o", 1, word_t'(rvalid_o));
        end
        req_i   = 1'b1;
        we_i    = we;
        addr_i  = addr;
        wdata_i = wdata;
        be_i    = be;
        if (we) begin
            model_write(addr, wdata, be);
            exp_q.push_back('0);
        end else begin
            exp_q.push_back(ref_read(addr));
        end
        waited = 0;
        @(posedge clk_i);
        check_value("gnt_o", 1, word_t'(gnt_o));  // granted in the request cycle
        while (!gnt_o && waited < TIMEOUT) begin
            waited++;
            @(posedge clk_i);
        end
        if (!gnt_o) begin
            error_count++;
            $display("Error at %0t ns: request to %h was never granted", $time, addr);
        end
    endtask

    task automatic bus_release();
        @(negedge clk_i);
        check_value("rvalid_o", 1, word_t'(rvalid_o));  // one cycle after the last grant
        req_i = 1'b0;
        we_i  = 1'b0;
        be_i  = '0;
    endtask

    // responses are popped on falling edges, so look on rising ones
    task automatic wait_responses();
        int waited;
        waited = 0;
        @(posedge clk_i);
        while (exp_q.size() != 0 && waited < TIMEOUT) begin
            waited++;
            @(posedge clk_i);
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("Error at %0t ns: %0d responses never arrived", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic bus_write(word_t addr, word_t wdata, be_t be);
        bus_issue(1'b1, addr, wdata, be, 1'b0);
        bus_release();
        wait_responses();
    endtask

    task automatic bus_read(word_t addr);
        bus_issue(1'b0, addr, '0, 4'hF, 1'b0);
        bus_release();
        wait_responses();
    endtask

    task automatic wait_irq(int t, logic level);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (irq_o[t] !== level && waited < TIMEOUT) begin
            waited++;
            @(negedge clk_i);
        end
        if (irq_o[t] !== level) begin
            error_count++;
            $display("Error at %0t ns: irq_o[%0d] never went to %b", $time, t, level);
        end
    endtask

    task automatic end_test(string name);
        int errs;
        errs = error_count - errors_at_start;
        test_count++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d errors", test_count, name, errs);
        errors_at_start = error_count;
    endtask

    // every response against the head of the queue
    always @(negedge clk_i) begin
        if (!reset_i && rvalid_o) begin
            if (exp_q.size() == 0) begin
                error_count++;
                $display("Error at %0t ns: rvalid_o without an outstanding request", $time);
            end else begin
                check_value("rdata_o", exp_q.pop_front(), rdata_o);
            end
        end
    end

    initial begin
        int    t;
        int    t2;
        word_t addr;
        void'($urandom(12));
        reset_i = 1'b1;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wdata_i = '0;
        be_i    = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            model_ctrl[i]   = '0;
            model_reload[i] = '0;
            model_count[i]  = '0;
        end
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        check_value("irq_o", '0, word_t'(irq_o));
        for (int i = 0; i < NUM_TIMERS; i++) begin
            bus_read(reg_addr(i, timer_bus_pkg::REG_CTRL));
            bus_read(reg_addr(i, timer_bus_pkg::REG_RELOAD));
            bus_read(reg_addr(i, timer_bus_pkg::REG_COUNT));
        end
        end_test("reset state");

        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < NUM_TIMERS; i++) begin
                bus_write(reg_addr(i, timer_bus_pkg::REG_RELOAD), $urandom,
                          be_t'($urandom_range(15, 1)));
                for (int j = 0; j < NUM_TIMERS; j++) begin
                    bus_read(reg_addr(j, timer_bus_pkg::REG_RELOAD));
                end
            end
        end
        end_test("register access");

        for (int k = 0; k < 8; k++) begin
            addr = miss_addr();
            bus_write(addr, $urandom, 4'hF);
            bus_read(addr);
        end
        for (int i = 0; i < NUM_TIMERS; i++) begin
            bus_read(reg_addr(i, timer_bus_pkg::REG_CTRL));
            bus_read(reg_addr(i, timer_bus_pkg::REG_RELOAD));
        end
        end_test("unmapped accesses");

        // req_i held high for one response per cycle
        for (int k = 0; k < 16; k++) begin
            if ($urandom_range(3, 0) == 3) begin
                addr = miss_addr();
            end else begin
                addr = reg_addr($urandom_range(NUM_TIMERS - 1, 0), 8'($urandom_range(3, 0) * 4));
            end
            bus_issue(1'b0, addr, '0, 4'hF, k > 0);
        end
        bus_release();
        wait_responses();
        end_test("pipelined traffic");

        t = $urandom_range(NUM_TIMERS - 1, 0);
        bus_write(reg_addr(t, timer_bus_pkg::REG_RELOAD), $urandom_range(20, 3), 4'hF);
        bus_write(reg_addr(t, timer_bus_pkg::REG_CTRL), EN_BIT | IRQ_EN_BIT, 4'h1);
        wait_irq(t, 1'b1);
        check_value("irq_o", word_t'(1) << t, word_t'(irq_o));
        model_ctrl[t]  = IRQ_EN_BIT | PEND_BIT;  // one-shot stopped
        model_count[t] = model_reload[t];
        bus_read(reg_addr(t, timer_bus_pkg::REG_CTRL));
        bus_read(reg_addr(t, timer_bus_pkg::REG_COUNT));
        bus_write(reg_addr(t, timer_bus_pkg::REG_CTRL), IRQ_EN_BIT | PEND_BIT, 4'h1);
        wait_irq(t, 1'b0);
        bus_read(reg_addr(t, timer_bus_pkg::REG_CTRL));
        end_test("one-shot");

        t2 = (t + 1) % NUM_TIMERS;
        bus_write(reg_addr(t2, timer_bus_pkg::REG_RELOAD), $urandom_range(20, 6), 4'hF);
        bus_write(reg_addr(t2, timer_bus_pkg::REG_CTRL), EN_BIT | IRQ_EN_BIT | AUTO_BIT, 4'h1);
        wait_irq(t2, 1'b1);
        bus_write(reg_addr(t2, timer_bus_pkg::REG_CTRL),
                  EN_BIT | IRQ_EN_BIT | AUTO_BIT | PEND_BIT, 4'h1);
        wait_irq(t2, 1'b0);
        wait_irq(t2, 1'b1);
        check_value("irq_o", word_t'(1) << t2, word_t'(irq_o));
        model_ctrl[t2] = EN_BIT | IRQ_EN_BIT | AUTO_BIT | PEND_BIT;
        bus_read(reg_addr(t2, timer_bus_pkg::REG_CTRL));
        bus_write(reg_addr(t2, timer_bus_pkg::REG_CTRL), PEND_BIT, 4'h1);
        wait_irq(t2, 1'b0);
        end_test("auto-reload");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/timer_subsys_assert.sv
// bus and interrupt assertions
`timescale 1ns/10ps

module timer_subsys_assert #(
    parameter int NUM_TIMERS = 3
) (
    input logic                  clk_i,
    input logic                  reset_i,
    input logic                  req_i,
    input logic                  gnt_o,
    input logic                  rvalid_o,
    input logic [NUM_TIMERS-1:0] irq_o
);

    // accepted request answered on the next cycle
    rvalid_follows_accept: assert property (
        @(posedge clk_i) disable iff (reset_i)
        req_i && gnt_o |=> rvalid_o
    ) else $error("rvalid_o missing after an accepted request");

    rvalid_needs_accept: assert property (
        @(posedge clk_i) disable iff (reset_i)
        rvalid_o |-> $past(req_i && gnt_o)
    ) else $error("rvalid_o without an accepted request");

    // first reset edge clears the irq flops
    irq_low_in_reset: assert property (
        @(posedge clk_i)
        reset_i && $past(reset_i) |-> irq_o == '0
    ) else $error("irq_o high during reset");

endmodule

bind timer_subsys_top timer_subsys_assert #(
    .NUM_TIMERS (NUM_TIMERS)
) u_assert (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .irq_o    (irq_o)
);

//--- design/timer_subsys_top.sv
// timer subsystem top level
`timescale 1ns/10ps

module timer_subsys_top #(
    parameter int NUM_TIMERS = 3  // 1 to 16
) (
    input  logic                     clk_i,
    input  logic                     reset_i,

    // bus master side
    input  logic                     req_i,
    input  logic                     we_i,
    input  timer_bus_pkg::bus_word_t addr_i,
    input  timer_bus_pkg::bus_word_t wdata_i,
    input  timer_bus_pkg::byte_en_t  be_i,
    output logic                     gnt_o,
    output logic                     rvalid_o,
    output timer_bus_pkg::bus_word_t rdata_o,

    output logic [NUM_TIMERS-1:0]    irq_o   // one per timer
);

    logic [timer_bus_pkg::TIMER_IDX_BITS-1:0] resp_sel;
    logic                                     resp_miss;
    logic                                     req_accepted;

    obi_slave_if tmr_bus [NUM_TIMERS] ();

    assign req_accepted = req_i & gnt_o;

    obi_addr_decoder #(
        .NUM_TIMERS (NUM_TIMERS)
    ) u_decoder (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .be_i        (be_i),
        .gnt_o       (gnt_o),
        .resp_sel_o  (resp_sel),
        .resp_miss_o (resp_miss),
        .tmr         (tmr_bus)
    );

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
        timer_unit u_timer (
            .clk_i   (clk_i),
            .reset_i (reset_i),
            .bus     (tmr_bus[i]),
            .irq_o   (irq_o[i])
        );
    end

    obi_resp_mux #(
        .NUM_TIMERS (NUM_TIMERS)
    ) u_resp_mux (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_accepted_i (req_accepted),
        .resp_sel_i     (resp_sel),
        .resp_miss_i    (resp_miss),
        .tmr            (tmr_bus),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o)
    );

endmodule

//--- design/obi_resp_mux.sv
// response path back to the bus master
`timescale 1ns/10ps

module obi_resp_mux #(
    parameter int NUM_TIMERS = 3
) (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     req_accepted_i,
    input  logic [timer_bus_pkg::TIMER_IDX_BITS-1:0] resp_sel_i,
    input  logic                                     resp_miss_i,
    obi_slave_if.slave                               tmr [NUM_TIMERS],
    output logic                                     rvalid_o,
    output timer_bus_pkg::bus_word_t                 rdata_o
);

    localparam int IDX_BITS = timer_bus_pkg::TIMER_IDX_BITS;

    logic [IDX_BITS-1:0]      sel_q;
    logic                     miss_q;
    logic [NUM_TIMERS-1:0]    tmr_rvalid;
    timer_bus_pkg::bus_word_t tmr_rdata [NUM_TIMERS];
    logic                     sel_rvalid;
    timer_bus_pkg::bus_word_t sel_rdata;

    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_resp
        assign tmr_rvalid[i] = tmr[i].rvalid;
        assign tmr_rdata[i]  = tmr[i].rdata;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sel_q  <= '0;
            miss_q <= 1'b0;
        end else begin
            miss_q <= req_accepted_i & resp_miss_i;  // one cycle pulse
            if (req_accepted_i) begin
                sel_q <= resp_sel_i;
            end
        end
    end

    always_comb begin
        sel_rvalid = 1'b0;
        sel_rdata  = '0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (sel_q == IDX_BITS'(i)) begin
                sel_rvalid = tmr_rvalid[i];
                sel_rdata  = tmr_rdata[i];
            end
        end
    end

    // unmapped access answers with zero data
    assign rvalid_o = miss_q | sel_rvalid;
    assign rdata_o  = miss_q ? '0 : sel_rdata;

endmodule

//--- design/timer_unit.sv
// bus mapped down-counting timer
`timescale 1ns/10ps

module timer_unit (
    input  logic       clk_i,
    input  logic       reset_i,
    obi_slave_if.slave bus,
    output logic       irq_o
);

    localparam int OFS_BITS = timer_bus_pkg::TIMER_STRIDE_LSB;
    localparam int EN       = timer_bus_pkg::CTRL_EN;
    localparam int IRQ_EN   = timer_bus_pkg::CTRL_IRQ_EN;
    localparam int PENDING  = timer_bus_pkg::CTRL_PENDING;
    localparam int AUTO     = timer_bus_pkg::CTRL_AUTO;

    logic [3:0]                ctrl_q;
    timer_bus_pkg::bus_word_t  reload_q;
    timer_bus_pkg::bus_word_t  count_q;
    timer_bus_pkg::bus_word_t  read_word;
    timer_bus_pkg::bus_word_t  rdata_q;
    logic                      rvalid_q;
    logic                      irq_q;
    logic [OFS_BITS-1:0]       offset;
    logic                      accept;
    logic                      wr_ctrl;
    logic                      wr_reload;
    logic                      pend_clr;
    logic                      expire;

    assign bus.gnt = 1'b1;  // never stalls
    assign accept  = bus.req & bus.gnt;
    assign offset  = bus.addr[OFS_BITS-1:0];

    // control bits all live in byte lane 0
    assign wr_ctrl   = accept & bus.we & bus.be[0] & (offset == timer_bus_pkg::REG_CTRL);
    assign wr_reload = accept & bus.we & (offset == timer_bus_pkg::REG_RELOAD);
    assign pend_clr  = wr_ctrl & bus.wdata[PENDING];
    assign expire    = ctrl_q[EN] & (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q  <= '0;
            count_q <= '0;
        end else begin
            // a timeout in the same cycle beats a software clear
            ctrl_q[PENDING] <= expire | (ctrl_q[PENDING] & ~pend_clr);

            if (wr_ctrl) begin
                ctrl_q[EN]     <= bus.wdata[EN];
                ctrl_q[IRQ_EN] <= bus.wdata[IRQ_EN];
                ctrl_q[AUTO]   <= bus.wdata[AUTO];
            end else if (expire && !ctrl_q[AUTO]) begin
                ctrl_q[EN] <= 1'b0;  // one-shot stops
            end

            if ((wr_ctrl && bus.wdata[EN]) || expire) begin
                count_q <= reload_q;
            end else if (ctrl_q[EN]) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            reload_q <= '0;
        end else if (wr_reload) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.be[b]) begin
                    reload_q[8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        unique case (offset)
            timer_bus_pkg::REG_CTRL:   read_word = timer_bus_pkg::bus_word_t'(ctrl_q);
            timer_bus_pkg::REG_RELOAD: read_word = reload_q;
            timer_bus_pkg::REG_COUNT:  read_word = count_q;
            default:                   read_word = '0;  // hole in the map
        endcase
    end

    // response one cycle after acceptance
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            rdata_q <= bus.we ? '0 : read_word;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= ctrl_q[PENDING] & ctrl_q[IRQ_EN];
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign irq_o      = irq_q;

endmodule

//--- design/obi_addr_decoder.sv
// timer region address decoder
`timescale 1ns/10ps

module obi_addr_decoder #(
    parameter int NUM_TIMERS = 3
) (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     req_i,
    input  logic                                     we_i,
    input  timer_bus_pkg::bus_word_t                 addr_i,
    input  timer_bus_pkg::bus_word_t                 wdata_i,
    input  timer_bus_pkg::byte_en_t                  be_i,
    output logic                                     gnt_o,
    output logic [timer_bus_pkg::TIMER_IDX_BITS-1:0] resp_sel_o,
    output logic                                     resp_miss_o,
    obi_slave_if.master                              tmr [NUM_TIMERS]
);

    localparam int IDX_BITS = timer_bus_pkg::TIMER_IDX_BITS;
    localparam int IDX_LSB  = timer_bus_pkg::TIMER_STRIDE_LSB;

    logic                  region_hit;
    logic [IDX_BITS-1:0]   idx;
    logic                  hit;
    logic [NUM_TIMERS-1:0] tmr_gnt;
    logic                  sel_gnt;

    assign region_hit = (addr_i & timer_bus_pkg::TIMER_REGION_MASK)
                        == timer_bus_pkg::TIMER_REGION_BASE;
    assign idx        = addr_i[IDX_LSB +: IDX_BITS];
    assign hit        = region_hit && (int'(idx) < NUM_TIMERS);  // index past the array misses

    // request goes to one link only, payload is shared
    for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_link
        assign tmr[i].req   = req_i & hit & (idx == IDX_BITS'(i));
        assign tmr[i].addr  = addr_i;
        assign tmr[i].we    = we_i;
        assign tmr[i].be    = be_i;
        assign tmr[i].wdata = wdata_i;
        assign tmr_gnt[i]   = tmr[i].gnt;
    end

    always_comb begin
        sel_gnt = 1'b0;
        for (int i = 0; i < NUM_TIMERS; i++) begin
            if (idx == IDX_BITS'(i)) begin
                sel_gnt = tmr_gnt[i];
            end
        end
    end

    // misses are granted here and never reach a timer
    assign gnt_o       = req_i & (hit ? sel_gnt : 1'b1);
    assign resp_sel_o  = idx;
    assign resp_miss_o = ~hit;

endmodule

//--- design/obi_slave_if.sv
// request/grant bus link to one slave
`timescale 1ns/10ps

interface obi_slave_if;

    logic                      req;
    logic                      gnt;
    timer_bus_pkg::bus_word_t  addr;
    logic                      we;
    timer_bus_pkg::byte_en_t   be;
    timer_bus_pkg::bus_word_t  wdata;

    // response, one cycle after acceptance
    logic                      rvalid;
    timer_bus_pkg::bus_word_t  rdata;

    modport master (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport slave (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

//--- design/timer_bus_pkg.sv
// timer subsystem bus definitions

package timer_bus_pkg;

    // one bus word, data or address
    typedef logic [31:0] bus_word_t;

    // one enable bit per byte lane
    typedef logic [3:0] byte_en_t;

    // timer region, 4 KiB at the peripheral base
    localparam bus_word_t TIMER_REGION_BASE = 32'h4000_0000;
    localparam bus_word_t TIMER_REGION_MASK = 32'hFFFF_F000;

    // each timer owns 256 bytes, index sits above the offset
    localparam int TIMER_STRIDE_LSB = 8;
    localparam int TIMER_IDX_BITS   = 4;

    // register offsets inside one timer
    localparam logic [TIMER_STRIDE_LSB-1:0] REG_CTRL   = 8'h00;
    localparam logic [TIMER_STRIDE_LSB-1:0] REG_RELOAD = 8'h04;
    localparam logic [TIMER_STRIDE_LSB-1:0] REG_COUNT  = 8'h08;  // read only

    // control register bits
    localparam int CTRL_EN      = 0;
    localparam int CTRL_IRQ_EN  = 1;
    localparam int CTRL_PENDING = 2;  // write 1 to clear
    localparam int CTRL_AUTO    = 3;

endpackage
